/* rtl/mmio_pkg.sv */
`default_nettype none

package mmio_pkg;

    // data memory geometry
    localparam int mem_words      = 1024;
    localparam int mem_index_bits = 10;

    // address map, one word per uart register
    localparam logic [31:0] uart_tx_base = 32'hf000_0000;
    localparam logic [31:0] uart_rx_base = 32'hf000_0010;
    localparam logic [31:0] mtimer_base  = 32'hf000_0100;
    localparam logic [31:0] mtimer_last  = 32'hf000_010f;

    // uart bit timing
    localparam int clks_per_bit = 8;
    localparam int baud_bits    = $clog2(clks_per_bit);

    // last count of a full bit and of half a bit
    localparam logic [baud_bits-1:0] baud_last = baud_bits'(clks_per_bit - 1);
    localparam logic [baud_bits-1:0] baud_half = baud_bits'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {
        mem,
        utx,
        urx,
        tmr
    } target_t;

    // command from the master, start travels beside it
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
        logic        rdata_valid;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* rtl/mmio_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module mmio_decoder (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start,
    input  wire mmio_pkg::bus_req_t req,
    output mmio_pkg::bus_rsp_t  rsp,

    output logic                mem_start,
    output mmio_pkg::bus_req_t  mem_req,
    input  wire mmio_pkg::bus_rsp_t mem_rsp,

    output logic                utx_start,
    output mmio_pkg::bus_req_t  utx_req,
    input  wire mmio_pkg::bus_rsp_t utx_rsp,

    output logic                urx_start,
    output mmio_pkg::bus_req_t  urx_req,
    input  wire mmio_pkg::bus_rsp_t urx_rsp,

    output logic                tmr_start,
    output mmio_pkg::bus_req_t  tmr_req,
    input  wire mmio_pkg::bus_rsp_t tmr_rsp
);

    logic               is_utx;
    logic               is_urx;
    logic               is_tmr;
    mmio_pkg::target_t  hit_tgt;
    mmio_pkg::target_t  sel_q;

    // single-word uart windows only need the upper address bits
    assign is_utx = (req.addr[31:2] == mmio_pkg::uart_tx_base[31:2]);
    assign is_urx = (req.addr[31:2] == mmio_pkg::uart_rx_base[31:2]);
    assign is_tmr = (req.addr >= mmio_pkg::mtimer_base) &&
                    (req.addr <= mmio_pkg::mtimer_last);

    always_comb begin
        if (is_utx) begin
            hit_tgt = mmio_pkg::utx;
        end else if (is_urx) begin
            hit_tgt = mmio_pkg::urx;
        end else if (is_tmr) begin
            hit_tgt = mmio_pkg::tmr;
        end else begin
            // everything else lands in memory and wraps
            hit_tgt = mmio_pkg::mem;
        end
    end

    assign mem_start = start && (hit_tgt == mmio_pkg::mem);
    assign utx_start = start && (hit_tgt == mmio_pkg::utx);
    assign urx_start = start && (hit_tgt == mmio_pkg::urx);
    assign tmr_start = start && (hit_tgt == mmio_pkg::tmr);

    // rebased copies of the request
    assign mem_req = req;
    assign utx_req = '{write: req.write, addr: req.addr - mmio_pkg::uart_tx_base,
                       wdata: req.wdata};
    assign urx_req = '{write: req.write, addr: req.addr - mmio_pkg::uart_rx_base,
                       wdata: req.wdata};
    assign tmr_req = '{write: req.write, addr: req.addr - mmio_pkg::mtimer_base,
                       wdata: req.wdata};

    // remember who took the last command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= mmio_pkg::mem;
        end else if (start && rsp.ready) begin
            sel_q <= hit_tgt;
        end
    end

    // response follows the registered target, not the live address
    always_comb begin
        unique case (sel_q)
            mmio_pkg::utx: rsp = utx_rsp;
            mmio_pkg::urx: rsp = urx_rsp;
            mmio_pkg::tmr: rsp = tmr_rsp;
            default:       rsp = mem_rsp;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/data_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module data_memory (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire mmio_pkg::bus_req_t req,
    output mmio_pkg::bus_rsp_t      rsp
);

    logic [31:0]                        mem_q [mmio_pkg::mem_words];
    logic [mmio_pkg::mem_index_bits-1:0] idx;
    logic [31:0]                        rdata_q;
    logic                               rvalid_q;

    // word index, upper bits ignored
    assign idx = req.addr[mmio_pkg::mem_index_bits+1:2];

    always_ff @(posedge clk) begin
        if (start && req.write) begin
            mem_q[idx] <= req.wdata;
        end
        rdata_q <= mem_q[idx];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= start && !req.write;
        end
    end

    // never stalls
    assign rsp = '{ready: 1'b1, rdata: rdata_q, rdata_valid: rvalid_q};

endmodule

`default_nettype wire

/* rtl/uart_tx_port.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_tx_port (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire mmio_pkg::bus_req_t req,
    output mmio_pkg::bus_rsp_t      rsp,
    output logic                    txd
);

    logic                          busy_q;
    logic [9:0]                    shift_q;
    logic [mmio_pkg::baud_bits-1:0] baud_cnt_q;
    logic [3:0]                    bit_cnt_q;
    logic                          rvalid_q;
    logic [31:0]                   rdata_q;
    logic                          accept;

    assign accept = start && !busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            shift_q    <= '1;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            rvalid_q   <= 1'b0;
        end else begin
            rvalid_q <= accept && !req.write;
            if (!busy_q) begin
                if (accept && req.write) begin
                    // stop bit, data lsb first, start bit
                    busy_q     <= 1'b1;
                    shift_q    <= {1'b1, req.wdata[7:0], 1'b0};
                    baud_cnt_q <= '0;
                    bit_cnt_q  <= '0;
                end
            end else if (baud_cnt_q == mmio_pkg::baud_last) begin
                baud_cnt_q <= '0;
                shift_q    <= {1'b1, shift_q[9:1]};
                if (bit_cnt_q == 4'd9) begin
                    // stop bit done
                    busy_q <= 1'b0;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                end
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
        end
    end

    // status read, busy in bit 0
    always_ff @(posedge clk) begin
        if (accept && !req.write) begin
            rdata_q <= {31'b0, busy_q};
        end
    end

    // line idles high since the register fills with ones
    assign txd = shift_q[0];

    assign rsp = '{ready: !busy_q, rdata: rdata_q, rdata_valid: rvalid_q};

endmodule

`default_nettype wire

/* rtl/uart_rx_port.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_rx_port (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire mmio_pkg::bus_req_t req,
    input  wire                     rxd,
    output mmio_pkg::bus_rsp_t      rsp
);

    logic                          sync1_q;
    logic                          sync2_q;
    logic                          prev_q;
    logic                          busy_q;
    logic [mmio_pkg::baud_bits-1:0] baud_cnt_q;
    logic [3:0]                    bit_cnt_q;
    logic [7:0]                    data_q;
    logic [7:0]                    held_q;
    logic                          valid_q;
    logic                          rvalid_q;
    logic [31:0]                   rdata_q;
    logic                          sample;
    logic                          rd;

    assign rd = start && !req.write;

    // start bit waits half a bit, the rest a full bit
    assign sample = busy_q && ((bit_cnt_q == 4'd0) ? (baud_cnt_q == mmio_pkg::baud_half)
                                                   : (baud_cnt_q == mmio_pkg::baud_last));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q    <= 1'b1;
            sync2_q    <= 1'b1;
            prev_q     <= 1'b1;
            busy_q     <= 1'b0;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            valid_q    <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            sync1_q  <= rxd;
            sync2_q  <= sync1_q;
            prev_q   <= sync2_q;
            rvalid_q <= rd;
            if (rd) begin
                valid_q <= 1'b0;
            end
            if (!busy_q) begin
                // falling edge opens a frame
                if (prev_q && !sync2_q) begin
                    busy_q     <= 1'b1;
                    baud_cnt_q <= '0;
                    bit_cnt_q  <= '0;
                end
            end else if (sample) begin
                baud_cnt_q <= '0;
                bit_cnt_q  <= bit_cnt_q + 4'd1;
                if (bit_cnt_q == 4'd0 && sync2_q) begin
                    // glitch, not a start bit
                    busy_q <= 1'b0;
                end else if (bit_cnt_q == 4'd9) begin
                    busy_q <= 1'b0;
                    if (sync2_q) begin
                        valid_q <= 1'b1;
                    end
                end
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (sample && bit_cnt_q >= 4'd1 && bit_cnt_q <= 4'd8) begin
            data_q <= {sync2_q, data_q[7:1]};
        end
        if (sample && bit_cnt_q == 4'd9 && sync2_q) begin
            held_q <= data_q;
        end
        if (rd) begin
            rdata_q <= {23'b0, valid_q, held_q};
        end
    end

    assign rsp = '{ready: 1'b1, rdata: rdata_q, rdata_valid: rvalid_q};

endmodule

`default_nettype wire

/* rtl/machine_timer_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module machine_timer_regs (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire mmio_pkg::bus_req_t req,
    input  wire [63:0]              mtime,
    output mmio_pkg::bus_rsp_t      rsp,
    output logic                    timer_irq
);

    logic [63:0] mtimecmp_q;
    logic [31:0] rdata_q;
    logic        rvalid_q;
    logic [1:0]  word;

    // 0 mtime lo, 1 mtime hi, 2 cmp lo, 3 cmp hi
    assign word = req.addr[3:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // all ones keeps the irq quiet
            mtimecmp_q <= '1;
            rvalid_q   <= 1'b0;
            timer_irq  <= 1'b0;
        end else begin
            rvalid_q  <= start && !req.write;
            timer_irq <= (mtime >= mtimecmp_q);
            if (start && req.write) begin
                case (word)
                    2'd2:    mtimecmp_q[31:0]  <= req.wdata;
                    2'd3:    mtimecmp_q[63:32] <= req.wdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !req.write) begin
            case (word)
                2'd0:    rdata_q <= mtime[31:0];
                2'd1:    rdata_q <= mtime[63:32];
                2'd2:    rdata_q <= mtimecmp_q[31:0];
                default: rdata_q <= mtimecmp_q[63:32];
            endcase
        end
    end

    assign rsp = '{ready: 1'b1, rdata: rdata_q, rdata_valid: rvalid_q};

endmodule

`default_nettype wire

/* rtl/mmio_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mmio_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire mmio_pkg::bus_req_t req,
    input  wire                     rxd,
    input  wire [63:0]              mtime,
    output mmio_pkg::bus_rsp_t      rsp,
    output logic                    txd,
    output logic                    timer_irq
);

    logic               mem_start;
    logic               utx_start;
    logic               urx_start;
    logic               tmr_start;
    mmio_pkg::bus_req_t mem_req;
    mmio_pkg::bus_req_t utx_req;
    mmio_pkg::bus_req_t urx_req;
    mmio_pkg::bus_req_t tmr_req;
    mmio_pkg::bus_rsp_t mem_rsp;
    mmio_pkg::bus_rsp_t utx_rsp;
    mmio_pkg::bus_rsp_t urx_rsp;
    mmio_pkg::bus_rsp_t tmr_rsp;

    mmio_decoder i_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .req       (req),
        .rsp       (rsp),
        .mem_start (mem_start),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .utx_start (utx_start),
        .utx_req   (utx_req),
        .utx_rsp   (utx_rsp),
        .urx_start (urx_start),
        .urx_req   (urx_req),
        .urx_rsp   (urx_rsp),
        .tmr_start (tmr_start),
        .tmr_req   (tmr_req),
        .tmr_rsp   (tmr_rsp)
    );

    data_memory i_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mem_start),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

    uart_tx_port i_uart_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .start (utx_start),
        .req   (utx_req),
        .rsp   (utx_rsp),
        .txd   (txd)
    );

    uart_rx_port i_uart_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .start (urx_start),
        .req   (urx_req),
        .rxd   (rxd),
        .rsp   (urx_rsp)
    );

    machine_timer_regs i_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (tmr_start),
        .req       (tmr_req),
        .mtime     (mtime),
        .rsp       (tmr_rsp),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

/* bench/tb_mmio_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mmio_top;

    typedef enum logic [3:0] {
        op_wr, op_wr_rand, op_rd, op_rd_mem, op_tx, op_rd_mtime, op_cmp_ahead, op_irq, op_pair
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_val;
        logic [31:0] rd_mask;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               start;
    mmio_pkg::bus_req_t req;
    mmio_pkg::bus_rsp_t rsp;
    logic               txd;
    logic               timer_irq;
    logic [63:0]        mtime;

    row_t        rows[$];
    string       row_names[$];
    logic [31:0] ref_mem [0:1023];
    logic [31:0] lfsr_q = 32'h67d5;
    logic        table_built = 1'b0;
    int          cycle_count = 0;
    int          cycle_limit;
    int          checks = 0;
    int          errors = 0;

    // txd loops straight back into rxd
    mmio_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .req       (req),
        .rxd       (txd),
        .mtime     (mtime),
        .rsp       (rsp),
        .txd       (txd),
        .timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // free-running mtime, moved with the other inputs
    initial begin
        mtime = 64'd0;
        forever begin
            @(posedge clk);
            #1;
            mtime <= mtime + 64'd1;
        end
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    // memory wraps on addr bits 11..2
    function automatic int mem_index(input logic [31:0] addr);
        return int'(addr[11:2]);
    endfunction

    function automatic void add_row(input op_t op, input logic [31:0] addr,
                                    input logic [31:0] wdata, input logic [31:0] exp_val,
                                    input logic [31:0] rd_mask, input string name);
        row_t r;
        r.op = op;
        r.addr = addr;
        r.wdata = wdata;
        r.exp_val = exp_val;
        r.rd_mask = rd_mask;
        rows.push_back(r);
        row_names.push_back(name);
    endfunction

    function automatic void build_table();
        add_row(op_wr_rand, 32'h0000_0004, 0, 0, 0, "mem_wr_004");
        add_row(op_wr_rand, 32'h0000_0008, 0, 0, 0, "mem_wr_008");
        add_row(op_wr_rand, 32'h0000_0ffc, 0, 0, 0, "mem_wr_ffc");
        add_row(op_wr_rand, 32'h0000_0100, 0, 0, 0, "mem_wr_100");
        add_row(op_rd_mem, 32'h0000_0008, 0, 0, '1, "mem_rd_008");
        add_row(op_rd_mem, 32'h0000_0004, 0, 0, '1, "mem_rd_004");
        add_row(op_rd_mem, 32'h0000_0ffc, 0, 0, '1, "mem_rd_ffc");
        add_row(op_rd_mem, 32'h0000_1004, 0, 0, '1, "mem_wrap_1004");
        add_row(op_rd_mem, 32'h0000_0100, 0, 0, '1, "mem_rd_100");
        add_row(op_tx, mmio_pkg::uart_tx_base, 32'h5c, 0, 0, "utx_write_busy");
        add_row(op_rd, mmio_pkg::uart_tx_base, 0, 32'h0, 32'h1, "utx_status_idle");
        add_row(op_rd, mmio_pkg::uart_rx_base, 0, 32'h15c, 32'h1ff, "urx_loopback");
        add_row(op_rd, mmio_pkg::uart_rx_base, 0, 32'h0, 32'h100, "urx_flag_cleared");
        add_row(op_rd_mtime, mmio_pkg::mtimer_base, 0, 0, '1, "mtime_lo_window");
        add_row(op_rd, mmio_pkg::mtimer_base + 32'd12, 0, '1, '1, "mtimecmp_hi_reset");
        add_row(op_cmp_ahead, mmio_pkg::mtimer_base, 32'd12, 0, 0, "mtimecmp_compare");
        add_row(op_wr, mmio_pkg::mtimer_base + 32'd8, '1, 0, 0, "mtimecmp_lo_ones");
        add_row(op_wr, mmio_pkg::mtimer_base + 32'd12, '1, 0, 0, "mtimecmp_hi_ones");
        add_row(op_irq, 0, 0, 32'h0, 32'h1, "irq_cleared");
        add_row(op_rd, mmio_pkg::mtimer_base + 32'd8, 0, '1, '1, "mtimecmp_lo_readback");
        add_row(op_pair, mmio_pkg::uart_rx_base, 32'h0000_0ffc, 32'h5c, 32'h1ff,
                "urx_then_mem");
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ready();
        while (!rsp.ready) next_cycle();
    endtask

    // one accepted command, returns one cycle after acceptance
    task automatic drive_cmd(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
        wait_ready();
        start = 1'b1;
        req.write = wr;
        req.addr = addr;
        req.wdata = wdata;
        next_cycle();
        start = 1'b0;
        req.write = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act, input logic [31:0] rd_mask);
        checks++;
        assert ((act & rd_mask) == (exp_val & rd_mask)) else begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp_val & rd_mask, act & rd_mask);
        end
    endtask

    task automatic get_read_data(input string name, output logic [31:0] data,
                                 output logic ok);
        int waited;
        waited = 0;
        while (!rsp.rdata_valid && waited < 4) begin
            next_cycle();
            waited++;
        end
        ok = rsp.rdata_valid;
        data = rsp.rdata;
        checks++;
        assert (ok) else begin
            errors++;
            $display("%s: read response never arrived within 4 cycles", name);
        end
    endtask

    // urx read and memory read accepted on consecutive edges
    // the urx response is sampled with the memory address already driven
    task automatic back_to_back_reads(input row_t row, input string name);
        logic [31:0] first;
        logic        first_ok;
        start = 1'b1;
        req.write = 1'b0;
        req.addr = row.addr;
        next_cycle();
        req.addr = row.wdata;
        #1;
        first = rsp.rdata;
        first_ok = rsp.rdata_valid;
        next_cycle();
        start = 1'b0;
        checks++;
        assert (first_ok && rsp.rdata_valid) else begin
            errors++;
            $display("%s: a back-to-back read lost its response pulse", name);
        end
        check_value(name, row.exp_val, first, row.rd_mask);
        check_value({name, "_mem"}, ref_mem[mem_index(row.wdata)], rsp.rdata, '1);
    endtask

    task automatic run_row(input row_t row, input string name);
        logic [31:0] data;
        logic [31:0] word;
        logic        ok;
        logic [63:0] t0;
        logic [63:0] target;
        wait_ready();
        case (row.op)
            op_wr: drive_cmd(1'b1, row.addr, row.wdata);
            op_wr_rand: begin
                draw_word(word);
                ref_mem[mem_index(row.addr)] = word;
                drive_cmd(1'b1, row.addr, word);
            end
            op_rd, op_rd_mem: begin
                drive_cmd(1'b0, row.addr, 32'h0);
                get_read_data(name, data, ok);
                if (ok) begin
                    if (row.op == op_rd_mem) begin
                        check_value(name, ref_mem[mem_index(row.addr)], data, row.rd_mask);
                    end else begin
                        check_value(name, row.exp_val, data, row.rd_mask);
                    end
                end
            end
            op_tx: begin
                // ready must fall right after the write is taken
                drive_cmd(1'b1, row.addr, row.wdata);
                check_value(name, 32'h0, {31'b0, rsp.ready}, 32'h1);
            end
            op_rd_mtime: begin
                t0 = mtime;
                drive_cmd(1'b0, row.addr, 32'h0);
                get_read_data(name, data, ok);
                checks++;
                assert (!ok || (data >= t0[31:0] && data <= mtime[31:0])) else begin
                    errors++;
                    $display("FAIL %s expected %h..%h actual %h", name, t0[31:0],
                             mtime[31:0], data);
                end
            end
            op_cmp_ahead: begin
                target = mtime + 64'(row.wdata);
                drive_cmd(1'b1, row.addr + 32'd8, target[31:0]);
                drive_cmd(1'b1, row.addr + 32'd12, target[63:32]);
                // irq reflects the mtime value seen on the same edge
                for (int i = 0; i < int'(row.wdata) + 4; i++) begin
                    check_value(name, {31'b0, mtime >= target}, {31'b0, timer_irq}, 32'h1);
                    next_cycle();
                end
            end
            op_irq: begin
                next_cycle();
                check_value(name, row.exp_val, {31'b0, timer_irq}, row.rd_mask);
            end
            default: back_to_back_reads(row, name);
        endcase
    endtask

    initial begin : watchdog
        wait (table_built);
        cycle_limit = rows.size() * 10 * mmio_pkg::clks_per_bit + 200;
        while (cycle_count < cycle_limit) @(posedge clk);
        $display("timeout: the run went past %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        rst_n = 1'b0;
        start = 1'b0;
        req = '0;
        build_table();
        table_built = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("reset_ready", 32'h1, {31'b0, rsp.ready}, 32'h1);
        check_value("reset_rdata_valid", 32'h0, {31'b0, rsp.rdata_valid}, 32'h1);
        check_value("reset_txd", 32'h1, {31'b0, txd}, 32'h1);
        check_value("reset_timer_irq", 32'h0, {31'b0, timer_irq}, 32'h1);
        for (int r = 0; r < rows.size(); r++) begin
            run_row(rows[r], row_names[r]);
        end
        repeat (4) next_cycle();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mmio_top.f */
rtl/mmio_pkg.sv
rtl/mmio_decoder.sv
rtl/data_memory.sv
rtl/uart_tx_port.sv
rtl/uart_rx_port.sv
rtl/machine_timer_regs.sv
rtl/mmio_top.sv
bench/tb_mmio_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mmio testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
    --top-module tb_mmio_top \
    -f mmio_top.f \
    -o sim_tb_mmio_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_mmio_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
